// File: all.f
+incdir+.
aes_ctrl_pkg.sv
aes_data_pkg.sv
aes_sbox.sv
aes_key_expander.sv
aes_datapath.sv
aes_control_unit.sv
aes_core.sv
tb_clock_gen.sv
tb_aes_core.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_aes_core
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_aes_core.sv
// ===================================================================
// AES-128 core testbench
// ===================================================================
`timescale 1ns/100ps
`default_nettype none
`include "aes_macros.svh"

module tb_aes_core;

	localparam int CLK_NS       = 8;
	localparam int RESET_CYCLES = 4;
	localparam int BLOCK_CYCLES = 60;
	localparam int MAX_BLOCKS   = 40;
	localparam int WATCHDOG_NS  = MAX_BLOCKS * BLOCK_CYCLES * CLK_NS
		+ (RESET_CYCLES + 4) * CLK_NS;
	// Edges after the start edge until end_comp shows
	localparam int ENC_LAT = 5 * `AES_NR + 1;
	localparam int KEY_LAT = `AES_NR + 1;

	// FIPS-197 Appendix B
	localparam logic [`AES_BLOCK_W-1:0] FIPS_KEY   = 128'h2b7e151628aed2a6abf7158809cf4f3c;
	localparam logic [`AES_BLOCK_W-1:0] FIPS_PT    = 128'h3243f6a8885a308d313198a2e0370734;
	localparam logic [`AES_BLOCK_W-1:0] FIPS_CT    = 128'h3925841d02dc09fbdc118597196a0b32;
	localparam logic [`AES_BLOCK_W-1:0] FIPS_KEY10 = 128'hd014f9a8c9ee2589e13f0cc8b6630ca6;

	logic                      clk;
	logic                      rst_n;
	logic                      start;
	logic                      disable_core;
	aes_ctrl_pkg::operation_e  operation_mode;
	aes_ctrl_pkg::aes_mode_e   aes_mode;
	logic [`AES_BLOCK_W-1:0]   key_in;
	logic [`AES_BLOCK_W-1:0]   data_in;
	logic [`AES_BLOCK_W-1:0]   iv_in;
	logic                      iv_load;
	logic [`AES_BLOCK_W-1:0]   data_out;
	logic                      end_comp;
	logic [3:0]                round;

	// Request from stimulus to the compare process
	logic                      chk_req;
	string                     chk_name;
	logic [`AES_BLOCK_W-1:0]   chk_exp;
	int                        chk_lat;
	bit                        chk_end;
	int                        n_tests;
	int                        n_fail;

	// Reference S-box, built below
	logic [7:0]                sbox_tab [256];

	tb_clock_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(RESET_CYCLES)) u_clk
	(
		.clk   (clk),
		.rst_n (rst_n)
	);

	aes_core uut
	(
		.clk (clk), .rst_n (rst_n), .start (start), .disable_core (disable_core),
		.operation_mode (operation_mode), .aes_mode (aes_mode), .key_in (key_in),
		.data_in (data_in), .iv_in (iv_in), .iv_load (iv_load), .data_out (data_out),
		.end_comp (end_comp), .round (round)
	);

	// ===============================================================
	// Reference model
	// ===============================================================
	// Carry-less product, then reduce by 0x11B
	function automatic logic [7:0] ref_gmul(input logic [7:0] a, input logic [7:0] b);
		logic [14:0] p;
		p = '0;
		for (int i = 0; i < 8; i++)
			if (b[i])
				p = p ^ (15'(a) << i);
		for (int i = 14; i >= 8; i--)
			if (p[i])
				p = p ^ (15'h11b << (i - 8));
		return p[7:0];
	endfunction

	// Brute-force inverse, then the FIPS affine map
	initial
	begin : sbox_build
		logic [7:0] inv;
		logic [7:0] aff;
		for (int x = 0; x < 256; x++)
		begin
			// Zero keeps inverse zero
			inv = 8'h00;
			for (int y = 1; y < 256; y++)
				if (ref_gmul(8'(x), 8'(y)) == 8'h01)
					inv = 8'(y);
			for (int i = 0; i < 8; i++)
				aff[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8]
					^ inv[(i + 6) % 8] ^ inv[(i + 7) % 8];
			sbox_tab[x] = aff ^ 8'h63;
		end
	end

	// One step of the key schedule
	function automatic logic [127:0] ref_next_key(input logic [127:0] k, input logic [7:0] rc);
		logic [31:0] w [4];
		logic [31:0] t;
		for (int i = 0; i < 4; i++)
			w[i] = k[127 - 32*i -: 32];
		// RotWord then SubWord
		t = {sbox_tab[w[3][23:16]], sbox_tab[w[3][15:8]],
			sbox_tab[w[3][7:0]], sbox_tab[w[3][31:24]]};
		w[0] = w[0] ^ t ^ {rc, 24'h000000};
		for (int i = 1; i < 4; i++)
			w[i] = w[i] ^ w[i-1];
		return {w[0], w[1], w[2], w[3]};
	endfunction

	// SubBytes, ShiftRows, optional MixColumns, AddRoundKey
	function automatic logic [127:0] ref_round(input logic [127:0] s, input logic [127:0] k,
		input bit mix);
		logic [7:0]   a [16];
		logic [7:0]   b [16];
		logic [7:0]   coef [4];
		logic [7:0]   m;
		logic [127:0] r;
		coef = '{8'h02, 8'h03, 8'h01, 8'h01};
		for (int i = 0; i < 16; i++)
			a[i] = sbox_tab[s[127 - 8*i -: 8]];
		// Byte i is row i%4 of column i/4
		for (int c = 0; c < 4; c++)
			for (int row = 0; row < 4; row++)
				b[4*c + row] = a[4*((c + row) % 4) + row];
		for (int c = 0; c < 4; c++)
			for (int row = 0; row < 4; row++)
			begin
				m = 8'h00;
				for (int j = 0; j < 4; j++)
					m = m ^ ref_gmul(coef[(j + 4 - row) % 4], b[4*c + j]);
				r[127 - 8*(4*c + row) -: 8] = mix ? m : b[4*c + row];
			end
		return r ^ k;
	endfunction

	function automatic logic [127:0] aes_ref_encrypt(input logic [127:0] key,
		input logic [127:0] pt);
		logic [127:0] s;
		logic [127:0] k;
		logic [7:0]   rc;
		s = pt ^ key;
		k = key;
		rc = 8'h01;
		for (int r = 1; r <= `AES_NR; r++)
		begin
			k = ref_next_key(k, rc);
			rc = ref_gmul(rc, 8'h02);
			// No MixColumns in the final round
			s = ref_round(s, k, r != `AES_NR);
		end
		return s;
	endfunction

	function automatic logic [127:0] aes_ref_key10(input logic [127:0] key);
		logic [127:0] k;
		logic [7:0]   rc;
		k = key;
		rc = 8'h01;
		for (int r = 1; r <= `AES_NR; r++)
		begin
			k = ref_next_key(k, rc);
			rc = ref_gmul(rc, 8'h02);
		end
		return k;
	endfunction

	// Keystream from the counter, XORed with the block
	function automatic logic [127:0] aes_ref_ctr(input logic [127:0] key,
		input logic [127:0] ctr, input logic [127:0] data);
		return data ^ aes_ref_encrypt(key, ctr);
	endfunction

	function automatic logic [127:0] random_block();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	// ===============================================================
	// Stimulus tasks
	// ===============================================================
	// Start one block, hand the expected result to the compare process
	task automatic run_block(input string name, input aes_ctrl_pkg::operation_e op,
		input aes_ctrl_pkg::aes_mode_e mode, input logic [127:0] key,
		input logic [127:0] data, input logic [127:0] expected, input int latency,
		input bit abort);
		@(posedge clk);
		#1;
		operation_mode = op;
		aes_mode = mode;
		key_in = key;
		data_in = data;
		start = 1'b1;
		chk_name = name;
		chk_exp = expected;
		chk_lat = latency;
		chk_end = !abort;
		chk_req = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		// Abort somewhere in round 4
		if (abort)
		begin
			repeat (20)
				@(posedge clk);
			#1;
			disable_core = 1'b1;
			@(posedge clk);
			#1;
			disable_core = 1'b0;
		end
		wait (!chk_req);
	endtask

	task automatic load_iv(input logic [127:0] iv);
		@(posedge clk);
		#1;
		iv_in = iv;
		iv_load = 1'b1;
		@(posedge clk);
		#1;
		iv_load = 1'b0;
	endtask

	// One value compare outside the block flow, counted as a test
	task automatic check_value(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		n_tests++;
		if (actual === expected)
			$display("ok    %s", name);
		else
		begin
			n_fail++;
			$display("** Error %s: expected %h actual %h", name, expected, actual);
		end
	endtask

	// ===============================================================
	// Compare process
	// ===============================================================
	initial
	begin : compare_proc
		int lat;
		bit seen;
		forever
		begin
			wait (chk_req);
			// Start edge
			@(posedge clk);
			lat = 0;
			seen = 1'b0;
			while (!seen && lat < BLOCK_CYCLES)
			begin
				@(posedge clk);
				lat++;
				// Outputs settled mid-cycle
				@(negedge clk);
				seen = end_comp;
			end
			n_tests++;
			if (chk_end && !seen)
			begin
				n_fail++;
				$display("%s: no end_comp within %0d cycles", chk_name, BLOCK_CYCLES);
			end
			else if (!chk_end && seen)
			begin
				n_fail++;
				$display("%s: end_comp appeared after the core was disabled", chk_name);
			end
			else if (chk_end && data_out !== chk_exp)
			begin
				n_fail++;
				$display("** Error %s: expected %h actual %h", chk_name, chk_exp, data_out);
			end
			else if (chk_end && lat != chk_lat)
			begin
				n_fail++;
				$display("** Error %s latency: expected %0d actual %0d", chk_name,
					chk_lat, lat);
			end
			else
				$display("ok    %s", chk_name);
			chk_req = 1'b0;
		end
	end

	// ===============================================================
	// Test sequence
	// ===============================================================
	initial
	begin : stimulus
		logic [127:0] key;
		logic [127:0] pt;
		logic [127:0] iv;
		start = 1'b0;
		disable_core = 1'b0;
		operation_mode = aes_ctrl_pkg::ENCRYPTION;
		aes_mode = aes_ctrl_pkg::ECB;
		key_in = '0;
		data_in = '0;
		iv_in = '0;
		iv_load = 1'b0;
		chk_req = 1'b0;
		chk_end = 1'b0;
		chk_lat = 0;
		chk_exp = '0;
		n_tests = 0;
		n_fail = 0;
		void'($urandom(32'h7835));

		// end_comp and round read together as one value, both zero
		@(negedge clk);
		check_value("reset_hold", '0, 128'({end_comp, round}));
		wait (rst_n);
		// One free edge with start low, core must stay idle
		@(posedge clk);
		@(negedge clk);
		check_value("reset_release", '0, 128'({end_comp, round}));
		check_value("ref_model", FIPS_CT, aes_ref_encrypt(FIPS_KEY, FIPS_PT));

		run_block("fips_ecb", aes_ctrl_pkg::ENCRYPTION, aes_ctrl_pkg::ECB, FIPS_KEY,
			FIPS_PT, FIPS_CT, ENC_LAT, 1'b0);
		for (int i = 0; i < 20; i++)
		begin
			key = random_block();
			pt = random_block();
			run_block($sformatf("ecb_rand_%02d", i), aes_ctrl_pkg::ENCRYPTION,
				aes_ctrl_pkg::ECB, key, pt, aes_ref_encrypt(key, pt), ENC_LAT, 1'b0);
		end

		// Key schedule alone
		run_block("key_deriv_fips", aes_ctrl_pkg::KEY_DERIVATION, aes_ctrl_pkg::ECB,
			FIPS_KEY, '0, FIPS_KEY10, KEY_LAT, 1'b0);
		key = random_block();
		run_block("key_deriv_rand", aes_ctrl_pkg::KEY_DERIVATION, aes_ctrl_pkg::ECB,
			key, '0, aes_ref_key10(key), KEY_LAT, 1'b0);

		// CTR, counter steps once per block
		key = random_block();
		iv = random_block();
		load_iv(iv);
		for (int i = 0; i < 4; i++)
		begin
			pt = random_block();
			run_block($sformatf("ctr_blk_%0d", i), aes_ctrl_pkg::ENCRYPTION,
				aes_ctrl_pkg::CTR, key, pt, aes_ref_ctr(key, iv + 128'(i), pt),
				ENC_LAT, 1'b0);
		end

		// Abort a CTR block, counter must stay at iv+4
		pt = random_block();
		run_block("ctr_abort", aes_ctrl_pkg::ENCRYPTION, aes_ctrl_pkg::CTR, key, pt,
			'0, ENC_LAT, 1'b1);
		pt = random_block();
		run_block("ecb_after_abort", aes_ctrl_pkg::ENCRYPTION, aes_ctrl_pkg::ECB,
			FIPS_KEY, pt, aes_ref_encrypt(FIPS_KEY, pt), ENC_LAT, 1'b0);
		pt = random_block();
		run_block("ctr_after_abort", aes_ctrl_pkg::ENCRYPTION, aes_ctrl_pkg::CTR, key, pt,
			aes_ref_ctr(key, iv + 128'd4, pt), ENC_LAT, 1'b0);

		$display("Tests %0d  passed %0d  failed %0d", n_tests, n_tests - n_fail, n_fail);
		if (n_fail == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// Hard stop well past the longest expected run
	initial
	begin : watchdog
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, run did not finish", WATCHDOG_NS);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
// ===================================================================
// Testbench clock and reset
// ===================================================================
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen
#(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 4
)
(
	output logic clk,
	output logic rst_n
);

	// Free-running clock
	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD_NS / 2) clk = ~clk;
	end

	// Reset low for the first few edges, released just after an edge
	initial
	begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES)
			@(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: aes_core.sv
// ===================================================================
// AES-128 core top level
// ===================================================================
`timescale 1ns/100ps
`default_nettype none
`include "aes_macros.svh"

module aes_core
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     start,
	input  logic                     disable_core,
	input  aes_ctrl_pkg::operation_e operation_mode,
	input  aes_ctrl_pkg::aes_mode_e  aes_mode,
	input  logic [`AES_BLOCK_W-1:0]  key_in,
	input  logic [`AES_BLOCK_W-1:0]  data_in,
	input  logic [`AES_BLOCK_W-1:0]  iv_in,
	input  logic                     iv_load,
	output logic [`AES_BLOCK_W-1:0]  data_out,
	output logic                     end_comp,
	output logic [3:0]               round
);

	// Control to datapath and key expander
	logic [2:0]               sbox_sel;
	logic [3:0]               col_en;
	aes_ctrl_pkg::col_src_e   col_src;
	logic                     key_load, key_step, ctr_mode, iv_cnt_en, out_en, out_key;
	// Key expander and datapath exchange
	aes_data_pkg::aes_block_t round_key;
	aes_data_pkg::aes_word_t  g_word, sub_word;

	aes_control_unit u_ctrl
	(
		.clk (clk), .rst_n (rst_n), .start (start), .disable_core (disable_core),
		.operation_mode (operation_mode), .aes_mode (aes_mode), .sbox_sel (sbox_sel),
		.col_en (col_en), .col_src (col_src), .key_load (key_load), .key_step (key_step),
		.ctr_mode (ctr_mode), .last_round (), .iv_cnt_en (iv_cnt_en), .out_en (out_en),
		.out_key (out_key), .end_comp (end_comp), .round (round)
	);

	aes_datapath u_dp
	(
		.clk (clk), .rst_n (rst_n), .data_in (data_in), .iv_in (iv_in), .iv_load (iv_load),
		.round_key (round_key), .g_word (g_word), .sbox_sel (sbox_sel), .col_en (col_en),
		.col_src (col_src), .ctr_mode (ctr_mode), .iv_cnt_en (iv_cnt_en), .out_en (out_en),
		.out_key (out_key), .sub_word (sub_word), .data_out (data_out)
	);

	aes_key_expander u_key
	(
		.clk (clk), .rst_n (rst_n), .key_in (key_in), .key_load (key_load),
		.key_step (key_step), .sub_word (sub_word), .g_word (g_word), .round_key (round_key)
	);

endmodule

`default_nettype wire

// File: aes_control_unit.sv
// ===================================================================
// AES control FSM
// ===================================================================
`timescale 1ns/100ps
`default_nettype none
`include "aes_macros.svh"

module aes_control_unit
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     start,
	input  logic                     disable_core,
	input  aes_ctrl_pkg::operation_e operation_mode,
	input  aes_ctrl_pkg::aes_mode_e  aes_mode,
	output logic [2:0]               sbox_sel,
	output logic [3:0]               col_en,
	output aes_ctrl_pkg::col_src_e   col_src,
	output logic                     key_load,
	output logic                     key_step,
	output logic                     ctr_mode,
	output logic                     last_round,
	output logic                     iv_cnt_en,
	output logic                     out_en,
	output logic                     out_key,
	output logic                     end_comp,
	output logic [3:0]               round
);

	localparam logic [3:0] LAST_RND = 4'(`AES_NR);
	localparam logic [3:0] LAST_GEN = 4'(`AES_NR - 1);
	// Bit 2 picks the g-function
	localparam logic [2:0] SBOX_G = 3'b100;

	aes_ctrl_pkg::ctrl_state_e state, next_state;
	aes_ctrl_pkg::operation_e  op_q;
	logic                      start_ok;
	logic                      key_deriv;
	logic                      gen_done;

	// Reserved operations leave the core idle
	assign start_ok = start && (operation_mode == aes_ctrl_pkg::ENCRYPTION
		|| operation_mode == aes_ctrl_pkg::KEY_DERIVATION);
	assign key_deriv = (op_q == aes_ctrl_pkg::KEY_DERIVATION);
	assign last_round = (round == LAST_RND);
	assign gen_done = (round == LAST_GEN);
	assign end_comp = (state == aes_ctrl_pkg::READY);

	// ===============================================================
	// State, round counter, latched operation
	// ===============================================================
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= aes_ctrl_pkg::IDLE;
		else if (disable_core)
			state <= aes_ctrl_pkg::IDLE;
		else
			state <= next_state;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			round <= 4'd0;
		else if (state == aes_ctrl_pkg::IDLE)
			round <= 4'd0;
		else if (state == aes_ctrl_pkg::ROUND_KEY || state == aes_ctrl_pkg::GEN_KEY)
			round <= round + 4'd1;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			op_q <= aes_ctrl_pkg::ENCRYPTION;
			ctr_mode <= 1'b0;
		end
		else if (state == aes_ctrl_pkg::IDLE && start_ok)
		begin
			op_q <= operation_mode;
			ctr_mode <= (aes_mode == aes_ctrl_pkg::CTR);
		end
	end

	// Next state
	always_comb
	begin
		unique case (state)
			aes_ctrl_pkg::IDLE:
				next_state = start_ok ? aes_ctrl_pkg::ADD_KEY0 : aes_ctrl_pkg::IDLE;
			aes_ctrl_pkg::ADD_KEY0:
				next_state = key_deriv ? aes_ctrl_pkg::GEN_KEY : aes_ctrl_pkg::ROUND_KEY;
			aes_ctrl_pkg::ROUND_KEY:  next_state = aes_ctrl_pkg::ROUND_COL0;
			aes_ctrl_pkg::ROUND_COL0: next_state = aes_ctrl_pkg::ROUND_COL1;
			aes_ctrl_pkg::ROUND_COL1: next_state = aes_ctrl_pkg::ROUND_COL2;
			aes_ctrl_pkg::ROUND_COL2: next_state = aes_ctrl_pkg::ROUND_COL3;
			aes_ctrl_pkg::ROUND_COL3:
				next_state = last_round ? aes_ctrl_pkg::READY : aes_ctrl_pkg::ROUND_KEY;
			aes_ctrl_pkg::GEN_KEY:
				next_state = gen_done ? aes_ctrl_pkg::READY : aes_ctrl_pkg::GEN_KEY;
			default:
				next_state = aes_ctrl_pkg::IDLE;
		endcase
	end

	// ===============================================================
	// Datapath and key controls
	// ===============================================================
	always_comb
	begin
		sbox_sel = 3'b000;
		col_en = 4'b0000;
		col_src = aes_ctrl_pkg::SUB_BYTES;
		key_load = 1'b0;
		key_step = 1'b0;
		iv_cnt_en = 1'b0;
		out_en = 1'b0;
		out_key = 1'b0;
		unique case (state)
			aes_ctrl_pkg::IDLE:
			begin
				// INPUT with no enable tells the datapath we are idle
				col_src = aes_ctrl_pkg::INPUT;
				key_load = start_ok;
			end
			aes_ctrl_pkg::ADD_KEY0:
			begin
				col_src = aes_ctrl_pkg::INPUT;
				col_en = 4'b1111;
				// Key derivation takes its first schedule step here
				if (key_deriv)
				begin
					sbox_sel = SBOX_G;
					key_step = 1'b1;
				end
			end
			aes_ctrl_pkg::ROUND_KEY:
			begin
				sbox_sel = SBOX_G;
				key_step = 1'b1;
			end
			aes_ctrl_pkg::ROUND_COL0:
			begin
				sbox_sel = 3'd0;
				col_en = 4'b0001;
			end
			aes_ctrl_pkg::ROUND_COL1:
			begin
				sbox_sel = 3'd1;
				col_en = 4'b0010;
			end
			aes_ctrl_pkg::ROUND_COL2:
			begin
				sbox_sel = 3'd2;
				col_en = 4'b0100;
			end
			aes_ctrl_pkg::ROUND_COL3:
			begin
				// Column 3 substitution folds into the block update
				sbox_sel = 3'd3;
				col_en = 4'b1111;
				col_src = last_round ? aes_ctrl_pkg::ROUND_LAST : aes_ctrl_pkg::ROUND_MIX;
				out_en = last_round && !disable_core;
				iv_cnt_en = last_round && ctr_mode && !disable_core;
			end
			aes_ctrl_pkg::GEN_KEY:
			begin
				sbox_sel = SBOX_G;
				key_step = !gen_done;
				// Round-10 key is in place on the last cycle
				out_en = gen_done && !disable_core;
				out_key = gen_done;
			end
			default:
			begin
			end
		endcase
	end

	a_start_op: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> (operation_mode == aes_ctrl_pkg::ENCRYPTION
			|| operation_mode == aes_ctrl_pkg::KEY_DERIVATION))
		else $error("start with reserved operation_mode");

	a_end_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		end_comp |=> !end_comp)
		else $error("end_comp longer than one cycle");

	a_idle_col: assert property (@(posedge clk) disable iff (!rst_n)
		(state == aes_ctrl_pkg::IDLE) |-> (col_en == 4'b0000))
		else $error("column write while idle");

endmodule

`default_nettype wire

// File: aes_datapath.sv
// ===================================================================
// AES column-serial datapath
// ===================================================================
`timescale 1ns/100ps
`default_nettype none
`include "aes_macros.svh"

module aes_datapath
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic [`AES_BLOCK_W-1:0]  data_in,
	input  logic [`AES_BLOCK_W-1:0]  iv_in,
	input  logic                     iv_load,
	input  aes_data_pkg::aes_block_t round_key,
	input  aes_data_pkg::aes_word_t  g_word,
	input  logic [2:0]               sbox_sel,
	input  logic [`AES_NK-1:0]       col_en,
	input  aes_ctrl_pkg::col_src_e   col_src,
	input  logic                     ctr_mode,
	input  logic                     iv_cnt_en,
	input  logic                     out_en,
	input  logic                     out_key,
	output aes_data_pkg::aes_word_t  sub_word,
	output logic [`AES_BLOCK_W-1:0]  data_out
);

	aes_data_pkg::aes_block_t st, din_q, sr_in, sr_blk, mix_blk, rnd_blk, load_blk, next_blk;
	aes_data_pkg::aes_word_t  sbox_in;
	logic [`AES_BLOCK_W-1:0]  ctr;
	logic                     idle;

	// Row r of column c comes from column c+r
	function automatic aes_data_pkg::aes_block_t shift_rows(input aes_data_pkg::aes_block_t s);
		aes_data_pkg::aes_block_t r;
		for (int c = 0; c < `AES_NK; c++)
			for (int b = 0; b < 4; b++)
				r[c][31 - 8*b -: 8] = s[(c + b) % `AES_NK][31 - 8*b -: 8];
		return r;
	endfunction

	// Circulant 02 03 01 01
	function automatic aes_data_pkg::aes_word_t mix_column(input aes_data_pkg::aes_word_t w);
		logic [7:0] a0, a1, a2, a3;
		logic [7:0] d0, d1, d2, d3;
		a0 = w[31:24];
		a1 = w[23:16];
		a2 = w[15:8];
		a3 = w[7:0];
		d0 = aes_data_pkg::gf_xtime(a0);
		d1 = aes_data_pkg::gf_xtime(a1);
		d2 = aes_data_pkg::gf_xtime(a2);
		d3 = aes_data_pkg::gf_xtime(a3);
		return {d0 ^ d1 ^ a1 ^ a2 ^ a3, a0 ^ d1 ^ d2 ^ a2 ^ a3,
			a0 ^ a1 ^ d2 ^ d3 ^ a3, d0 ^ a0 ^ a1 ^ a2 ^ d3};
	endfunction

	// Control holds INPUT with no column enable only when idle
	assign idle = (col_src == aes_ctrl_pkg::INPUT) && (col_en == '0);

	// Shared S-box, one column or the key g-function
	assign sbox_in = sbox_sel[2] ? g_word : st[sbox_sel[1:0]];

	aes_sbox u_sbox
	(
		.din  (sbox_in),
		.dout (sub_word)
	);

	// ===============================================================
	// Round logic
	// ===============================================================
	always_comb
	begin
		// Columns 0 to 2 already substituted, column 3 comes through the S-box
		sr_in = st;
		sr_in[`AES_NK-1] = sub_word;
		sr_blk = shift_rows(sr_in);
		for (int c = 0; c < `AES_NK; c++)
			mix_blk[c] = mix_column(sr_blk[c]);
		rnd_blk = ((col_src == aes_ctrl_pkg::ROUND_MIX) ? mix_blk : sr_blk) ^ round_key;
		// Key addition on load
		load_blk = (ctr_mode ? ctr : din_q) ^ round_key;
		unique case (col_src)
			aes_ctrl_pkg::INPUT:     next_blk = load_blk;
			aes_ctrl_pkg::SUB_BYTES: next_blk = {`AES_NK{sub_word}};
			default:                 next_blk = rnd_blk;
		endcase
	end

	always_ff @(posedge clk)
	begin
		for (int c = 0; c < `AES_NK; c++)
			if (col_en[c])
				st[c] <= next_blk[c];
		// Last idle cycle is the start edge
		if (idle)
			din_q <= data_in;
		if (out_en)
			data_out <= out_key ? round_key : (ctr_mode ? rnd_blk ^ din_q : rnd_blk);
	end

	// CTR counter, wraps at 2^128
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			ctr <= '0;
		else if (iv_load && idle)
			ctr <= iv_in;
		else if (iv_cnt_en)
			ctr <= ctr + 1'b1;
	end

	a_iv_busy: assert property (@(posedge clk) disable iff (!rst_n)
		(iv_load && !idle) |-> !iv_cnt_en)
		else $error("iv_load during counter advance");

endmodule

`default_nettype wire

// File: aes_key_expander.sv
// ===================================================================
// AES-128 round key expander
// ===================================================================
`timescale 1ns/100ps
`default_nettype none
`include "aes_macros.svh"

module aes_key_expander
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  aes_data_pkg::aes_block_t key_in,
	input  logic                     key_load,
	input  logic                     key_step,
	input  aes_data_pkg::aes_word_t  sub_word,
	output aes_data_pkg::aes_word_t  g_word,
	output aes_data_pkg::aes_block_t round_key
);

	logic [7:0]               rcon;
	aes_data_pkg::aes_block_t next_key;

	// RotWord of the last key word, S-box is in the datapath
	assign g_word = {round_key[`AES_NK-1][23:0], round_key[`AES_NK-1][31:24]};

	// Whole next key in one cycle
	always_comb
	begin
		next_key[0] = round_key[0] ^ sub_word ^ {rcon, 24'h000000};
		// Words 1 to 3 chain off the new word before
		for (int i = 1; i < `AES_NK; i++)
			next_key[i] = round_key[i] ^ next_key[i-1];
	end

	always_ff @(posedge clk)
	begin
		if (key_load)
			round_key <= key_in;
		else if (key_step)
			round_key <= next_key;
	end

	// Round constant, 01 then doubling
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rcon <= 8'h01;
		else if (key_load)
			rcon <= 8'h01;
		else if (key_step)
			rcon <= aes_data_pkg::gf_xtime(rcon);
	end

	a_load_step: assert property (@(posedge clk) disable iff (!rst_n)
		!(key_load && key_step))
		else $error("key load and key step together");

endmodule

`default_nettype wire

// File: aes_sbox.sv
// ===================================================================
// Forward S-box, four bytes wide
// ===================================================================
`timescale 1ns/100ps
`default_nettype none

module aes_sbox
(
	input  aes_data_pkg::aes_word_t din,
	output aes_data_pkg::aes_word_t dout
);

	// One byte through inverse and affine map
	function automatic logic [7:0] sub_byte(input logic [7:0] x);
		logic [7:0] sq;
		logic [7:0] inv;
		sq = x;
		inv = 8'h01;
		// x^254 built from x^2 up to x^128
		// zero maps to zero on its own
		for (int i = 0; i < 7; i++)
		begin
			sq = aes_data_pkg::gf_mul(sq, sq);
			inv = aes_data_pkg::gf_mul(inv, sq);
		end
		// Affine transform
		return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
			^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
	endfunction

	// Row 0 byte is the top byte
	always_comb
	begin
		for (int b = 0; b < 4; b++)
			dout[31 - 8*b -: 8] = sub_byte(din[31 - 8*b -: 8]);
	end

endmodule

`default_nettype wire

// File: aes_data_pkg.sv
// ===================================================================
// AES data types and GF(2^8) arithmetic
// ===================================================================
`default_nettype none
`include "aes_macros.svh"

package aes_data_pkg;

	typedef logic [31:0] aes_word_t;
	// Word 0 sits in the top bits
	typedef aes_word_t [0:`AES_NK-1] aes_block_t;

	// Multiply by x, reduce by 0x11B
	function automatic logic [7:0] gf_xtime(input logic [7:0] x);
		return {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
	endfunction

	// Shift and add product
	function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
		logic [7:0] p;
		logic [7:0] t;
		p = 8'h00;
		t = a;
		for (int i = 0; i < 8; i++)
		begin
			if (b[i])
				p = p ^ t;
			t = gf_xtime(t);
		end
		return p;
	endfunction

endpackage

`default_nettype wire

// File: aes_ctrl_pkg.sv
// ===================================================================
// AES control encodings
// ===================================================================
`default_nettype none

package aes_ctrl_pkg;

	// Operation select, upper half reserved
	typedef enum logic [1:0] {
		ENCRYPTION     = 2'b00,
		KEY_DERIVATION = 2'b01,
		OP_RSVD_2      = 2'b10,
		OP_RSVD_3      = 2'b11
	} operation_e;

	// Cipher mode, only ECB and CTR handled
	typedef enum logic [1:0] {
		ECB         = 2'b00,
		MODE_RSVD_1 = 2'b01,
		CTR         = 2'b10,
		MODE_RSVD_3 = 2'b11
	} aes_mode_e;

	typedef enum logic [3:0] {
		IDLE, ADD_KEY0, ROUND_KEY, ROUND_COL0, ROUND_COL1,
		ROUND_COL2, ROUND_COL3, GEN_KEY, READY
	} ctrl_state_e;

	// What a state column write takes
	typedef enum logic [1:0] {INPUT, SUB_BYTES, ROUND_MIX, ROUND_LAST} col_src_e;

endpackage

`default_nettype wire

// File: aes_macros.svh
// ===================================================================
// AES-128 core sizes
// ===================================================================
`ifndef AES_MACROS_SVH
`define AES_MACROS_SVH

// Rounds for a 128-bit key
`define AES_NR 10
// Block and key width
`define AES_BLOCK_W 128
// 32-bit words per key and per block
`define AES_NK 4

`endif
